// File: bench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset held low for 10 cycles, released away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/muldiv_tests.svh
`ifndef MULDIV_TESTS_SVH
`define MULDIV_TESTS_SVH

// ----------------------------------------------------------------------------
// helpers
// ----------------------------------------------------------------------------
task automatic clear_results();
  for (int i = 0; i < 2**TRANS_ID_W; i++) begin
    got_valid[i] = 1'b0;
    got_cycle[i] = 0;
  end
endtask

// one request on the next falling edge with its expected value kept by id
task automatic send(muldiv_op_e op, logic [31:0] a, logic [31:0] b, int id);
  @(negedge clk_i);
  valid_i        = 1'b1;
  op_i           = op;
  operand_a_i    = a;
  operand_b_i    = b;
  trans_id_i     = id[TRANS_ID_W-1:0];
  iss_cycle[id]  = cycle;
  exp_val[id]    = ref_result(op, a, b);
endtask

task automatic idle_cycle();
  @(negedge clk_i);
  valid_i = 1'b0;
endtask

task automatic wait_ready();
  int n;
  n = 0;
  while (!ready_o && n < 4 * DIV_CYCLES) begin
    @(negedge clk_i);
    n++;
  end
  if (!ready_o) begin
    $display("divider never became ready at %0t", $time);
    errors++;
  end
endtask

// polls on the rising edge after the capture at the falling edge
task automatic wait_result(int id, int limit);
  int n;
  n = 0;
  while (!got_valid[id] && n < limit) begin
    @(posedge clk_i);
    n++;
  end
endtask

task automatic check_result(int id, string what);
  if (!got_valid[id]) begin
    $display("no result came back for id %0d in %s", id, what);
    errors++;
  end else if (got_val[id] !== exp_val[id]) begin
    $display("ERROR %0t: %s id %0d got %h expected %h", $time, what, id,
             got_val[id], exp_val[id]);
    errors++;
  end
endtask

task automatic finish_test(string name, int err_start);
  if (errors == err_start) begin
    $display("%s: pass", name);
    tests_pass++;
  end else begin
    $display("%s: FAIL with %0d errors", name, errors - err_start);
    tests_fail++;
  end
endtask

// ----------------------------------------------------------------------------
// directed tests
// ----------------------------------------------------------------------------
task automatic test_reset_state();
  int e0;
  e0 = errors;
  @(posedge rst_ni);
  @(negedge clk_i);
  if (valid_o !== 1'b0 || ready_o !== 1'b1) begin
    $display("ERROR %0t: after reset valid_o=%b ready_o=%b", $time, valid_o, ready_o);
    errors++;
  end
  finish_test("reset state", e0);
endtask

task automatic test_multiply();
  muldiv_op_e  ops [4] = '{MUL, MULH, MULHU, MULHSU};
  logic [31:0] corner [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
  logic [31:0] a;
  logic [31:0] b;
  int          e0;
  e0 = errors;
  foreach (ops[k]) begin
    for (int batch = 0; batch < 3; batch++) begin
      clear_results();
      // eight requests back to back with one id each
      for (int id = 0; id < 8; id++) begin
        if (batch == 0 && id < 5) begin
          a = corner[id];
          b = corner[(id * 3 + k) % 5];
        end else begin
          a = $random(seed);
          b = $random(seed);
        end
        send(ops[k], a, b, id);
      end
      idle_cycle();
      for (int id = 0; id < 8; id++) begin
        wait_result(id, 10);
        check_result(id, ops[k].name());
        if (got_valid[id] && got_cycle[id] - iss_cycle[id] != 2) begin
          $display("ERROR %0t: %s id %0d latency %0d", $time, ops[k].name(), id,
                   got_cycle[id] - iss_cycle[id]);
          errors++;
        end
      end
    end
  end
  finish_test("multiplications", e0);
endtask

// one division and then ready_o must return
task automatic run_division(muldiv_op_e op, logic [31:0] a, logic [31:0] b, int id);
  clear_results();
  wait_ready();
  send(op, a, b, id);
  idle_cycle();
  wait_result(id, DIV_CYCLES + 10);
  check_result(id, op.name());
  @(negedge clk_i);
  if (!ready_o) begin
    $display("ERROR %0t: ready_o low after %s result", $time, op.name());
    errors++;
  end
endtask

task automatic test_divide();
  muldiv_op_e  ops [4] = '{DIV, DIVU, REM, REMU};
  logic [31:0] corner [4] = '{32'hffff_fff9, 32'h0000_0007, 32'h0000_0003, 32'h8000_0001};
  int          e0;
  e0 = errors;
  foreach (ops[k]) begin
    // signed corner pairs in every sign combination
    for (int i = 0; i < 4; i++) begin
      run_division(ops[k], corner[i], corner[(i + 1) % 4], i);
    end
    for (int i = 0; i < 10; i++) begin
      run_division(ops[k], $random(seed), $random(seed) >> (i % 24), i % 8);
    end
  end
  finish_test("divisions", e0);
endtask

task automatic test_special_cases();
  muldiv_op_e ops [4] = '{DIV, DIVU, REM, REMU};
  int         e0;
  e0 = errors;
  foreach (ops[k]) begin
    run_division(ops[k], 32'h1234_5678, 32'h0, 1);
    run_division(ops[k], 32'h8765_4321, 32'h0, 2);
    run_division(ops[k], 32'h0, 32'h0, 3);
    // most negative value by -1
    run_division(ops[k], 32'h8000_0000, 32'hffff_ffff, 4);
  end
  finish_test("special cases", e0);
endtask

task automatic test_priority();
  int e0;
  e0 = errors;
  clear_results();
  wait_ready();
  send(DIVU, 32'hdead_beef, 32'h0000_0123, 0);
  for (int i = 0; i < 28; i++) begin
    idle_cycle();
  end
  // a run of multiplications whose results overlap the division's finish
  for (int id = 1; id < 6; id++) begin
    send(MULHU, $random(seed), $random(seed), id);
  end
  idle_cycle();
  wait_result(0, DIV_CYCLES + 20);
  for (int id = 0; id < 6; id++) begin
    check_result(id, "priority");
  end
  for (int id = 1; id < 6; id++) begin
    if (got_valid[id] && got_cycle[id] - iss_cycle[id] != 2) begin
      $display("ERROR %0t: multiplication id %0d was delayed", $time, id);
      errors++;
    end
  end
  if (got_valid[0] && got_cycle[0] <= got_cycle[5]) begin
    $display("ERROR %0t: division result did not wait for the multiplications", $time);
    errors++;
  end
  finish_test("priority and back-pressure", e0);
endtask

task automatic test_flush();
  int e0;
  e0 = errors;
  clear_results();
  wait_ready();
  send(DIV, 32'h7654_3210, 32'h0000_0011, 6);
  for (int i = 0; i < 10; i++) begin
    idle_cycle();
  end
  @(negedge clk_i);
  flush_i = 1'b1;
  @(negedge clk_i);
  flush_i = 1'b0;
  if (!ready_o) begin
    $display("ERROR %0t: ready_o low after flush", $time);
    errors++;
  end
  repeat (DIV_CYCLES + 10) @(negedge clk_i);
  if (got_valid[6]) begin
    $display("flushed division id 6 still produced a result");
    errors++;
  end
  run_division(REM, 32'hfedc_ba98, 32'h0000_0345, 7);
  finish_test("flush", e0);
endtask

`endif

// File: bench/tb_muldiv.sv
`timescale 1ns/1ns
`default_nettype none

module tb_muldiv import muldiv_pkg::*; ();

  localparam int unsigned MAX_CYCLES = 20000;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  flush_i;
  logic                  valid_i;
  muldiv_op_e            op_i;
  logic [XLEN-1:0]       operand_a_i;
  logic [XLEN-1:0]       operand_b_i;
  logic [TRANS_ID_W-1:0] trans_id_i;
  logic                  ready_o;
  logic                  valid_o;
  logic [XLEN-1:0]       result_o;
  logic [TRANS_ID_W-1:0] trans_id_o;

  // result capture, indexed by transaction id
  logic                  got_valid [2**TRANS_ID_W];
  logic [XLEN-1:0]       got_val   [2**TRANS_ID_W];
  int                    got_cycle [2**TRANS_ID_W];
  int                    iss_cycle [2**TRANS_ID_W];
  logic [XLEN-1:0]       exp_val   [2**TRANS_ID_W];

  int                    cycle;
  int                    errors;
  int                    tests_pass;
  int                    tests_fail;
  integer                seed;

  tb_clock i_clk (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  muldiv_unit i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .trans_id_i  (trans_id_i),
    .ready_o     (ready_o),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .trans_id_o  (trans_id_o)
  );

  // --------------------------------------------------------------------------
  // reference model of the M extension
  // --------------------------------------------------------------------------
  function automatic logic [XLEN-1:0] ref_result(muldiv_op_e op, logic [31:0] a,
                                                 logic [31:0] b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] prod;
    int          sa;
    int          sb;
    // sign extension only where the opcode calls for a signed operand
    ea   = (op == MULH || op == MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
    eb   = (op == MULH) ? {{32{b[31]}}, b} : {32'b0, b};
    prod = ea * eb;
    sa   = a;
    sb   = b;
    case (op)
      MUL:    return a * b;
      MULH,
      MULHSU,
      MULHU:  return prod[63:32];
      DIV: begin
        if (b == 0) return '1;
        if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;
        return sa / sb;
      end
      DIVU:   return (b == 0) ? '1 : a / b;
      REM: begin
        if (b == 0) return a;
        if (a == 32'h8000_0000 && b == 32'hffff_ffff) return '0;
        return sa % sb;
      end
      default: return (b == 0) ? a : a % b;
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // run control
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("run stopped: cycle limit of %0d reached before the tests ended", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (rst_ni && valid_o) begin
      got_valid[trans_id_o] = 1'b1;
      got_val[trans_id_o]   = result_o;
      got_cycle[trans_id_o] = cycle;
    end
  end

  `include "muldiv_tests.svh"

  initial begin
    seed        = 32'hcdc3398d;
    cycle       = 0;
    errors      = 0;
    tests_pass  = 0;
    tests_fail  = 0;
    flush_i     = 1'b0;
    valid_i     = 1'b0;
    op_i        = MUL;
    operand_a_i = '0;
    operand_b_i = '0;
    trans_id_i  = '0;
    clear_results();

    test_reset_state();
    test_multiply();
    test_divide();
    test_special_cases();
    test_priority();
    test_flush();

    $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
             tests_pass, tests_fail, errors);
    if (errors == 0 && tests_fail == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/mul_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module mul_pipe import muldiv_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // request from dispatch, already qualified by opcode and flush
  input  logic                  valid_i,
  input  muldiv_op_e            op_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       operand_b_i,
  input  logic [TRANS_ID_W-1:0] trans_id_i,
  // result, one strobe per request, two cycles later
  output logic                  valid_o,
  output logic [XLEN-1:0]       result_o,
  output logic [TRANS_ID_W-1:0] trans_id_o
);

  // ---------------------------------------------------------------------------
  // stage one: operand extension
  // ---------------------------------------------------------------------------
  logic                  sign_a;
  logic                  sign_b;
  logic [XLEN:0]         a_ext;
  logic [XLEN:0]         b_ext;

  logic                  s1_valid_q;
  muldiv_op_e            s1_op_q;
  logic [TRANS_ID_W-1:0] s1_id_q;
  logic [XLEN:0]         s1_a_q;
  logic [XLEN:0]         s1_b_q;

  // operand a is signed for MULH and MULHSU, b only for MULH
  // MUL takes the low word, which is the same either way
  assign sign_a = (op_i inside {MUL, MULH, MULHSU}) & operand_a_i[XLEN-1];
  assign sign_b = (op_i inside {MUL, MULH}) & operand_b_i[XLEN-1];

  // 33 bit operands so one signed multiplier covers all four flavours
  assign a_ext = {sign_a, operand_a_i};
  assign b_ext = {sign_b, operand_b_i};

  // ---------------------------------------------------------------------------
  // stage two: product
  // ---------------------------------------------------------------------------
  logic                  s2_valid_q;
  muldiv_op_e            s2_op_q;
  logic [TRANS_ID_W-1:0] s2_id_q;
  logic [2*XLEN+1:0]     s2_prod_q;

  // valid bits only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  // datapath follows the valid bits
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      s1_op_q <= op_i;
      s1_id_q <= trans_id_i;
      s1_a_q  <= a_ext;
      s1_b_q  <= b_ext;
    end
    if (s1_valid_q) begin
      s2_op_q   <= s1_op_q;
      s2_id_q   <= s1_id_q;
      // full 66 bit signed product
      s2_prod_q <= $signed(s1_a_q) * $signed(s1_b_q);
    end
  end

  // ---------------------------------------------------------------------------
  // result word select
  // ---------------------------------------------------------------------------
  assign valid_o    = s2_valid_q;
  assign trans_id_o = s2_id_q;
  // low word for MUL, high word for the MULH variants
  assign result_o   = (s2_op_q == MUL) ? s2_prod_q[XLEN-1:0] : s2_prod_q[2*XLEN-1:XLEN];

endmodule

`default_nettype wire

// File: rtl/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------
  // operand and result width of the core
  localparam int unsigned XLEN       = 32;
  // transaction id travels with every request through either unit
  localparam int unsigned TRANS_ID_W = 3;

  // --------------------------------------------------------------------------
  // divider timing
  // --------------------------------------------------------------------------
  // one quotient bit per cycle
  localparam int unsigned DIV_CYCLES = XLEN;
  // iteration counter counts DIV_CYCLES-1 down to zero
  localparam int unsigned DIV_CNT_W  = $clog2(DIV_CYCLES);

  // --------------------------------------------------------------------------
  // opcodes
  // --------------------------------------------------------------------------
  // encoding follows funct3 of the M extension
  typedef enum logic [2:0] {
    MUL    = 3'b000,
    MULH   = 3'b001,
    MULHSU = 3'b010,
    MULHU  = 3'b011,
    DIV    = 3'b100,
    DIVU   = 3'b101,
    REM    = 3'b110,
    REMU   = 3'b111
  } muldiv_op_e;

  // divider control states
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    DIVIDE = 2'b01,
    FINISH = 2'b10
  } div_state_e;

endpackage

`default_nettype wire

// File: rtl/muldiv_unit.sv
`timescale 1ns/1ns
`default_nettype none

module muldiv_unit import muldiv_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // cancels a division and blocks new requests
  input  logic                  flush_i,
  // issue side
  input  logic                  valid_i,
  input  muldiv_op_e            op_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       operand_b_i,
  input  logic [TRANS_ID_W-1:0] trans_id_i,
  // divider readiness only, the multiplier never stalls
  output logic                  ready_o,
  // result side, consumer always accepts
  output logic                  valid_o,
  output logic [XLEN-1:0]       result_o,
  output logic [TRANS_ID_W-1:0] trans_id_o
);

  logic                  mul_req;
  logic                  div_req;
  logic                  div_signed;
  logic                  div_rem;

  logic                  mul_valid;
  logic [XLEN-1:0]       mul_result;
  logic [TRANS_ID_W-1:0] mul_id;

  logic                  div_valid;
  logic                  div_out_rdy;
  logic [XLEN-1:0]       div_result;
  logic [TRANS_ID_W-1:0] div_id;

  // ---------------------------------------------------------------------------
  // dispatch
  // ---------------------------------------------------------------------------
  // flush masks the request before it reaches either unit
  assign mul_req    = valid_i & ~flush_i & (op_i inside {MUL, MULH, MULHSU, MULHU});
  assign div_req    = valid_i & ~flush_i & (op_i inside {DIV, DIVU, REM, REMU});

  // divider flavour
  assign div_signed = op_i inside {DIV, REM};
  assign div_rem    = op_i inside {REM, REMU};

  // ---------------------------------------------------------------------------
  // multiplier
  // ---------------------------------------------------------------------------
  mul_pipe i_mul (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid_i     (mul_req),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .trans_id_i  (trans_id_i),
    .valid_o     (mul_valid),
    .result_o    (mul_result),
    .trans_id_o  (mul_id)
  );

  // ---------------------------------------------------------------------------
  // divider
  // ---------------------------------------------------------------------------
  serial_div i_div (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (flush_i),
    .in_vld_i  (div_req),
    .in_rdy_o  (ready_o),
    .signed_i  (div_signed),
    .rem_i     (div_rem),
    .op_a_i    (operand_a_i),
    .op_b_i    (operand_b_i),
    .id_i      (trans_id_i),
    .out_vld_o (div_valid),
    .out_rdy_i (div_out_rdy),
    .res_o     (div_result),
    .id_o      (div_id)
  );

  // ---------------------------------------------------------------------------
  // result arbiter
  // ---------------------------------------------------------------------------
  // fixed pipeline cannot stall, so the multiplier wins and the divider waits
  assign div_out_rdy = ~mul_valid;

  assign valid_o     = mul_valid | div_valid;
  assign result_o    = mul_valid ? mul_result : div_result;
  assign trans_id_o  = mul_valid ? mul_id : div_id;

  // nothing leaves the unit while in reset
  a_no_valid_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !valid_o);

  // a division result losing arbitration is still there next cycle
  a_div_held_on_collision: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mul_valid && div_valid && !flush_i) |=> div_valid && (div_id == $past(div_id)));

endmodule

`default_nettype wire

// File: rtl/serial_div.sv
`timescale 1ns/1ns
`default_nettype none

module serial_div import muldiv_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // drops any division in flight
  input  logic                  flush_i,
  // request side
  input  logic                  in_vld_i,
  output logic                  in_rdy_o,
  input  logic                  signed_i,
  input  logic                  rem_i,
  input  logic [XLEN-1:0]       op_a_i,
  input  logic [XLEN-1:0]       op_b_i,
  input  logic [TRANS_ID_W-1:0] id_i,
  // result side held until out_rdy_i
  output logic                  out_vld_o,
  input  logic                  out_rdy_i,
  output logic [XLEN-1:0]       res_o,
  output logic [TRANS_ID_W-1:0] id_o
);

  div_state_e            state_q, state_d;
  logic [DIV_CNT_W-1:0]  cnt_q, cnt_d;

  // dividend shifts out of quo at the top while quotient bits shift in
  logic [XLEN-1:0]       quo_q, quo_d;
  logic [XLEN-1:0]       part_q, part_d;
  logic [XLEN-1:0]       dvs_q, dvs_d;
  logic                  neg_quo_q, neg_quo_d;
  logic                  neg_rem_q, neg_rem_d;
  logic                  sel_rem_q, sel_rem_d;
  logic [TRANS_ID_W-1:0] id_q, id_d;

  logic                  accept;
  logic                  a_neg;
  logic                  b_neg;
  logic [XLEN-1:0]       a_mag;
  logic [XLEN-1:0]       b_mag;
  logic [XLEN:0]         part_shift;
  logic [XLEN:0]         part_diff;
  logic                  step_ok;
  logic [XLEN-1:0]       quo_res;
  logic [XLEN-1:0]       rem_res;

  // ---------------------------------------------------------------------------
  // operand magnitudes
  // ---------------------------------------------------------------------------
  assign accept = in_vld_i & in_rdy_o & ~flush_i;

  assign a_neg  = signed_i & op_a_i[XLEN-1];
  assign b_neg  = signed_i & op_b_i[XLEN-1];
  // most negative value maps onto 2**(XLEN-1) which still fits unsigned
  assign a_mag  = a_neg ? (~op_a_i + 1'b1) : op_a_i;
  assign b_mag  = b_neg ? (~op_b_i + 1'b1) : op_b_i;

  // ---------------------------------------------------------------------------
  // one restoring step
  // ---------------------------------------------------------------------------
  // partial remainder stays below the divisor, so one extra bit suffices
  assign part_shift = {part_q, quo_q[XLEN-1]};
  assign part_diff  = part_shift - {1'b0, dvs_q};
  // subtract only when it does not go negative
  // a zero divisor always succeeds and leaves all ones as quotient and the dividend as remainder
  assign step_ok    = ~part_diff[XLEN];

  // ---------------------------------------------------------------------------
  // control
  // ---------------------------------------------------------------------------
  always_comb begin
    state_d   = state_q;
    cnt_d     = cnt_q;
    quo_d     = quo_q;
    part_d    = part_q;
    dvs_d     = dvs_q;
    neg_quo_d = neg_quo_q;
    neg_rem_d = neg_rem_q;
    sel_rem_d = sel_rem_q;
    id_d      = id_q;

    unique case (state_q)
      IDLE: begin
        if (accept) begin
          state_d   = DIVIDE;
          cnt_d     = DIV_CNT_W'(DIV_CYCLES - 1);
          quo_d     = a_mag;
          part_d    = '0;
          dvs_d     = b_mag;
          // quotient keeps all ones on a zero divisor whatever the signs
          neg_quo_d = (a_neg ^ b_neg) & (op_b_i != '0);
          // remainder follows the dividend
          neg_rem_d = a_neg;
          sel_rem_d = rem_i;
          id_d      = id_i;
        end
      end
      DIVIDE: begin
        quo_d  = {quo_q[XLEN-2:0], step_ok};
        part_d = step_ok ? part_diff[XLEN-1:0] : part_shift[XLEN-1:0];
        if (cnt_q == '0) begin
          state_d = FINISH;
        end else begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      FINISH: begin
        // wait for the arbiter to take the result
        if (out_rdy_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase

    // flush wins over everything and discards the result
    if (flush_i) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // datapath registers
  always_ff @(posedge clk_i) begin
    quo_q     <= quo_d;
    part_q    <= part_d;
    dvs_q     <= dvs_d;
    neg_quo_q <= neg_quo_d;
    neg_rem_q <= neg_rem_d;
    sel_rem_q <= sel_rem_d;
    id_q      <= id_d;
  end

  // ---------------------------------------------------------------------------
  // sign restore and outputs
  // ---------------------------------------------------------------------------
  // overflow case lands here as quotient 2**(XLEN-1) with remainder zero
  assign quo_res   = neg_quo_q ? (~quo_q + 1'b1) : quo_q;
  assign rem_res   = neg_rem_q ? (~part_q + 1'b1) : part_q;

  assign in_rdy_o  = (state_q == IDLE);
  assign out_vld_o = (state_q == FINISH);
  assign res_o     = sel_rem_q ? rem_res : quo_res;
  assign id_o      = id_q;

  // ready comes back only once the result is taken or the division is flushed
  a_rdy_return: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(in_rdy_o) |-> $past(flush_i || (out_vld_o && out_rdy_i)));

  // stalled result keeps value and id until taken
  a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_vld_o && !out_rdy_i && !flush_i) |=>
      out_vld_o && $stable(res_o) && $stable(id_o));

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the muldiv testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_muldiv \
  -f verilog.f \
  -o sim_muldiv
status=$?
if [ $status -ne 0 ]; then
  echo "compile step failed with status $status"
  exit 1
fi

./obj_dir/sim_muldiv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi

// File: verilog.f
+incdir+bench
rtl/muldiv_pkg.sv
rtl/mul_pipe.sv
rtl/serial_div.sv
rtl/muldiv_unit.sv
bench/tb_clock.sv
bench/tb_muldiv.sv
